//--- rtl/dmem_pkg.sv
package dmem_pkg;

   // request address is a byte address.
   localparam int ADDR_W      = 13;
   localparam int WORD_ADDR_W = 11;
   localparam int MEM_WORDS   = 2048;

   localparam int DATA_W = 32;
   localparam int MASK_W = 4;
   localparam int LANE_W = DATA_W / MASK_W; // one byte per mask bit.
   localparam int TAG_W  = 4;

   // input queue depth, also the request credits upstream starts with.
   localparam int REQ_DEPTH = 4;
   localparam int RSP_DEPTH = 4;

   localparam int CRED_W = 3; // holds 0..4.

   typedef struct packed {
      logic              write;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [MASK_W-1:0] wmask;
      logic [TAG_W-1:0]  tag;
   } mem_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic [TAG_W-1:0]  tag;
   } mem_rsp_t;

endpackage

//--- rtl/sync_fifo.sv
module sync_fifo #(
   parameter type item_t = logic [7:0],
   parameter int  DEPTH  = 4
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  push,
   input  item_t push_data,
   input  logic  pop,
   output item_t pop_data,
   output logic  empty,
   output logic  full
);

   item_t mem [DEPTH];

   logic [$clog2(DEPTH)-1:0]   wr_ptr;
   logic [$clog2(DEPTH)-1:0]   rd_ptr;
   logic [$clog2(DEPTH+1)-1:0] count;

   // pointers wrap at DEPTH, which need not be a power of two.
   function automatic logic [$clog2(DEPTH)-1:0] next_ptr(
      input logic [$clog2(DEPTH)-1:0] ptr
   );
      if (ptr == $bits(ptr)'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // both or neither.
         endcase
      end
   end

   assign pop_data = mem[rd_ptr]; // show-ahead head.
   assign empty    = (count == '0);
   assign full     = (count == $bits(count)'(DEPTH));

   a_no_push_full: assert property (@(posedge clk) disable iff (rst)
      push |-> !full)
      else $error("sync_fifo: push while full");

   a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
      pop |-> !empty)
      else $error("sync_fifo: pop while empty");

endmodule

//--- rtl/mem_req_issue.sv
module mem_req_issue (
   input  logic               clk,
   input  logic               rst,
   input  logic               req_valid,
   input  dmem_pkg::mem_req_t req,
   input  logic               slot_free,
   output logic               req_credit,
   output logic               issue_valid,
   output dmem_pkg::mem_req_t issue
);

   import dmem_pkg::*;

   mem_req_t          head;
   logic              q_empty;
   logic              q_full;
   logic              do_pop;
   logic              rd_issue;
   logic [CRED_W-1:0] slot_cnt;

   sync_fifo #(
      .item_t (mem_req_t),
      .DEPTH  (REQ_DEPTH)
   ) req_q (
      .clk       (clk),
      .rst       (rst),
      .push      (req_valid),
      .push_data (req),
      .pop       (do_pop),
      .pop_data  (head),
      .empty     (q_empty),
      .full      (q_full)
   );

   // a read needs an output slot reserved; a write never does.
   assign do_pop   = !q_empty && (head.write || slot_cnt != '0);
   assign rd_issue = do_pop && !head.write;

   always_ff @(posedge clk) begin
      if (rst) begin
         issue_valid <= 1'b0;
         req_credit  <= 1'b0;
      end else begin
         issue_valid <= do_pop;
         req_credit  <= do_pop; // entry freed, hand the credit back.
      end
   end

   always_ff @(posedge clk) begin
      if (do_pop) begin
         issue <= head;
      end
   end

   // reserved output slots.
   always_ff @(posedge clk) begin
      if (rst) begin
         slot_cnt <= CRED_W'(RSP_DEPTH);
      end else begin
         case ({rd_issue, slot_free})
            2'b10:   slot_cnt <= slot_cnt - 1'b1;
            2'b01:   slot_cnt <= slot_cnt + 1'b1;
            default: slot_cnt <= slot_cnt;
         endcase
      end
   end

   // egress must never free more slots than reads were issued.
   a_slot_bound: assert property (@(posedge clk) disable iff (rst)
      slot_cnt <= CRED_W'(RSP_DEPTH))
      else $error("mem_req_issue: slot count above RSP_DEPTH");

   // upstream must respect its credits.
   a_req_credit: assert property (@(posedge clk) disable iff (rst)
      q_full |-> !req_valid)
      else $error("mem_req_issue: request without credit");

endmodule

//--- rtl/dmem_bram.sv
module dmem_bram (
   input  logic               clk,
   input  logic               rst,
   input  logic               issue_valid,
   input  dmem_pkg::mem_req_t issue,
   output logic               rd_valid,
   output dmem_pkg::mem_rsp_t rd_rsp
);

   import dmem_pkg::*;

   logic [DATA_W-1:0]      mem [MEM_WORDS];
   logic [WORD_ADDR_W-1:0] widx;
   logic                   wr_en;
   logic                   rd_en;

   // drop the byte offset.
   assign widx  = issue.addr[ADDR_W-1:2];
   assign wr_en = issue_valid && issue.write;
   assign rd_en = issue_valid && !issue.write;

   // mask bit 3 owns lane 0 and mask bit 0 owns lane 3.
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int i = 0; i < MASK_W; i++) begin
            if (issue.wmask[MASK_W-1-i]) begin
               mem[widx][i*LANE_W +: LANE_W] <= issue.wdata[i*LANE_W +: LANE_W];
            end
         end
      end
   end

   // registered read carries the tag along.
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_rsp.rdata <= mem[widx];
         rd_rsp.tag   <= issue.tag;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_en; // writes give no response.
      end
   end

endmodule

//--- rtl/mem_rsp_egress.sv
module mem_rsp_egress (
   input  logic               clk,
   input  logic               rst,
   input  logic               rd_valid,
   input  dmem_pkg::mem_rsp_t rd_rsp,
   input  logic               rsp_credit,
   output logic               rsp_valid,
   output dmem_pkg::mem_rsp_t rsp,
   output logic               slot_free
);

   import dmem_pkg::*;

   mem_rsp_t          head;
   logic              q_empty;
   logic              q_full;
   logic              do_pop;
   logic [CRED_W-1:0] cred_cnt;

   sync_fifo #(
      .item_t (mem_rsp_t),
      .DEPTH  (RSP_DEPTH)
   ) rsp_q (
      .clk       (clk),
      .rst       (rst),
      .push      (rd_valid),
      .push_data (rd_rsp),
      .pop       (do_pop),
      .pop_data  (head),
      .empty     (q_empty),
      .full      (q_full)
   );

   assign do_pop = !q_empty && cred_cnt != '0;

   // downstream credits start at zero.
   always_ff @(posedge clk) begin
      if (rst) begin
         cred_cnt <= '0;
      end else begin
         case ({rsp_credit, do_pop})
            2'b10:   cred_cnt <= cred_cnt + 1'b1;
            2'b01:   cred_cnt <= cred_cnt - 1'b1;
            default: cred_cnt <= cred_cnt;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_valid <= 1'b0;
         slot_free <= 1'b0;
      end else begin
         rsp_valid <= do_pop;
         slot_free <= do_pop; // slot goes back to the issue side.
      end
   end

   always_ff @(posedge clk) begin
      if (do_pop) begin
         rsp <= head;
      end
   end

   // downstream never holds more than RSP_DEPTH credits out.
   a_cred_bound: assert property (@(posedge clk) disable iff (rst)
      cred_cnt <= CRED_W'(RSP_DEPTH))
      else $error("mem_rsp_egress: downstream credits above RSP_DEPTH");

   // reservation on the issue side keeps the queue from overflowing.
   a_rsp_room: assert property (@(posedge clk) disable iff (rst)
      q_full |-> !rd_valid || do_pop)
      else $error("mem_rsp_egress: read arrived with no room");

endmodule

//--- rtl/dmem_subsystem.sv
module dmem_subsystem (
   input  logic               clk,
   input  logic               rst,
   input  logic               req_valid,
   input  dmem_pkg::mem_req_t req,
   input  logic               rsp_credit,
   output logic               req_credit,
   output logic               rsp_valid,
   output dmem_pkg::mem_rsp_t rsp
);

   import dmem_pkg::*;

   logic     issue_valid;
   mem_req_t issue;
   logic     rd_valid;
   mem_rsp_t rd_rsp;
   logic     slot_free;

   // input queue and issue.
   mem_req_issue u_issue (
      .clk         (clk),
      .rst         (rst),
      .req_valid   (req_valid),
      .req         (req),
      .slot_free   (slot_free),
      .req_credit  (req_credit),
      .issue_valid (issue_valid),
      .issue       (issue)
   );

   dmem_bram u_bram (
      .clk         (clk),
      .rst         (rst),
      .issue_valid (issue_valid),
      .issue       (issue),
      .rd_valid    (rd_valid),
      .rd_rsp      (rd_rsp)
   );

   // response queue against downstream credits.
   mem_rsp_egress u_egress (
      .clk        (clk),
      .rst        (rst),
      .rd_valid   (rd_valid),
      .rd_rsp     (rd_rsp),
      .rsp_credit (rsp_credit),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .slot_free  (slot_free)
   );

endmodule

//--- dv/dmem_tb.sv
module dmem_tb;

   import dmem_pkg::*;

   localparam int WAIT_MAX = 2000;

   logic     clk;
   logic     rst;
   logic     req_valid;
   mem_req_t req;
   logic     rsp_credit;
   logic     req_credit;
   logic     rsp_valid;
   mem_rsp_t rsp;

   logic [31:0]            lfsr;
   logic [DATA_W-1:0]      ref_mem [MEM_WORDS];
   mem_rsp_t               exp_q [$];
   logic [TAG_W-1:0]       tag_ctr;
   logic [WORD_ADDR_W-1:0] t2_idx [16];
   logic                   grant_next;
   int credit_mode; // 0 hold, 1 free, 2 random.
   int grant_pending;
   int rsp_out; // credits granted, not yet used.
   int rsp_seen;
   int reqs_sent;
   int credit_pulses;
   int errors;
   int n_checks;
   int n_tests;

   dmem_subsystem DUT (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (req_valid),
      .req        (req),
      .rsp_credit (rsp_credit),
      .req_credit (req_credit),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // galois form, taps for x^32 + x^22 + x^2 + x + 1.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // mask bit 3 selects bits 7:0, mask bit 0 selects bits 31:24.
   function automatic logic [DATA_W-1:0] masked_write(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] wdata,
                                                      input logic [MASK_W-1:0] mask);
      logic [DATA_W-1:0] v;
      v = old;
      if (mask[3]) v[7:0] = wdata[7:0];
      if (mask[2]) v[15:8] = wdata[15:8];
      if (mask[1]) v[23:16] = wdata[23:16];
      if (mask[0]) v[31:24] = wdata[31:24];
      return v;
   endfunction

   function automatic logic [DATA_W-1:0] fill_word(input logic [WORD_ADDR_W-1:0] idx);
      return {idx, 5'h15, ~idx, 5'h0a};
   endfunction

   function automatic int req_credits();
      return REQ_DEPTH - reqs_sent + credit_pulses;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic test_done(input string name, input int err_before);
      n_tests++;
      $display("test %0d %s: %0d errors", n_tests, name, errors - err_before);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
         req_valid = 1'b0;
      end
   endtask

   // one request, once upstream holds a credit.
   task automatic send_req(input logic wr, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata, input logic [MASK_W-1:0] mask);
      int                     waited;
      logic [WORD_ADDR_W-1:0] idx;
      mem_rsp_t               e;
      waited = 0;
      idx = addr[ADDR_W-1:2];
      idle(1);
      while (req_credits() == 0 && waited < WAIT_MAX) begin
         idle(1);
         waited++;
      end
      if (req_credits() == 0) begin
         errors++;
         $display("timeout at %0t: no request credit came back", $time);
      end else begin
         req.write = wr;
         req.addr  = addr;
         req.wdata = wdata;
         req.wmask = mask;
         req.tag   = tag_ctr;
         req_valid = 1'b1;
         reqs_sent++;
         if (wr) begin
            ref_mem[idx] = masked_write(ref_mem[idx], wdata, mask);
         end else begin
            e.rdata = ref_mem[idx];
            e.tag   = tag_ctr;
            exp_q.push_back(e);
         end
         tag_ctr++;
      end
   endtask

   task automatic wait_rsp(input int target);
      int waited;
      waited = 0;
      while (rsp_seen < target && waited < WAIT_MAX) begin
         idle(1);
         waited++;
      end
      if (rsp_seen < target) begin
         errors++;
         $display("timeout at %0t: an expected response never arrived", $time);
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      idle(1);
      while ((exp_q.size() != 0 || req_credits() != REQ_DEPTH) && waited < WAIT_MAX) begin
         idle(1);
         waited++;
      end
      if (exp_q.size() != 0 || req_credits() != REQ_DEPTH) begin
         errors++;
         $display("timeout at %0t: requests and responses did not drain", $time);
      end
   endtask

   // compares responses and decides the next downstream credit.
   initial begin : compare
      mem_rsp_t    e;
      logic [31:0] coin;
      forever begin
         @(negedge clk);
         if (!rst) begin
            if (req_credit) credit_pulses++;
            if (rsp_valid) begin
               rsp_seen++;
               if (exp_q.size() == 0) begin
                  errors++;
                  $display("error at %0t: response arrived with no read outstanding", $time);
               end else begin
                  e = exp_q.pop_front();
                  check("rsp.rdata", rsp.rdata, e.rdata);
                  check("rsp.tag", 32'(rsp.tag), 32'(e.tag));
               end
               if (rsp_out == 0) begin
                  errors++;
                  $display("error at %0t: response sent without a granted credit", $time);
               end else begin
                  rsp_out--;
               end
            end
            grant_next = 1'b0;
            if (rsp_out < RSP_DEPTH && rsp_out < exp_q.size()) begin
               if (grant_pending > 0) begin
                  grant_next = 1'b1;
                  grant_pending--;
               end else if (credit_mode == 1) begin
                  grant_next = 1'b1;
               end else if (credit_mode == 2) begin
                  coin = rand_bits(1);
                  grant_next = coin[0];
               end
            end
            if (grant_next) rsp_out++;
         end
      end
   end

   initial begin : credit_drive
      forever begin
         @(posedge clk);
         #1;
         rsp_credit = grant_next;
      end
   end

   initial begin
      logic [31:0] r_wr;
      logic [31:0] r_addr;
      logic [31:0] r_data;
      logic [31:0] r_mask;
      int          err0;
      int          base;
      rst = 1'b1;
      req_valid = 1'b0;
      req = '0;
      rsp_credit = 1'b0;
      lfsr = 32'hcf3abb3c;
      tag_ctr = '0;
      grant_next = 1'b0;
      credit_mode = 0;
      grant_pending = 0;
      rsp_out = 0;
      rsp_seen = 0;
      reqs_sent = 0;
      credit_pulses = 0;
      errors = 0;
      n_checks = 0;
      n_tests = 0;
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;

      err0 = errors;
      repeat (20) begin
         @(negedge clk);
         check("req_credit", 32'(req_credit), 32'd0);
         check("rsp_valid", 32'(rsp_valid), 32'd0);
      end
      test_done("idle after reset", err0);

      err0 = errors;
      credit_mode = 1;
      for (int i = 0; i < 16; i++) begin
         t2_idx[i] = WORD_ADDR_W'(i * 131 + 5);
         r_data = rand_bits(DATA_W);
         send_req(1'b1, {t2_idx[i], 2'(i)}, r_data, 4'hf);
      end
      for (int i = 0; i < 16; i++) send_req(1'b0, {t2_idx[i], 2'b00}, '0, '0);
      wait_drain();
      test_done("full word writes", err0);

      err0 = errors;
      send_req(1'b1, ADDR_W'(1000 * 4), 32'h1122_3344, 4'hf);
      send_req(1'b1, ADDR_W'(1000 * 4), 32'haabb_ccdd, 4'b1000);
      check("ref lane map", ref_mem[1000], 32'h1122_33dd);
      send_req(1'b0, ADDR_W'(1000 * 4), '0, '0);
      for (int i = 0; i < 8; i++) begin
         r_data = rand_bits(DATA_W);
         r_mask = rand_bits(MASK_W);
         send_req(1'b1, ADDR_W'(1000 * 4 + 1), r_data, r_mask[MASK_W-1:0]);
         send_req(1'b0, ADDR_W'(1000 * 4), '0, '0);
      end
      wait_drain();
      test_done("partial masks", err0);

      err0 = errors;
      credit_mode = 0;
      base = rsp_seen;
      for (int i = 0; i < 8; i++) send_req(1'b0, {t2_idx[i], 2'b00}, '0, '0);
      idle(20);
      check("responses held", rsp_seen - base, 0);
      check("request credits held", req_credits(), 0); // 8 requests in flight.
      for (int k = 1; k <= 8; k++) begin
         grant_pending = 1;
         wait_rsp(base + k);
         idle(4);
         check("responses per credit", rsp_seen - base, k);
      end
      wait_drain();
      test_done("back-pressure", err0);

      err0 = errors;
      credit_mode = 1;
      for (int i = 0; i < MEM_WORDS; i++) begin
         send_req(1'b1, ADDR_W'(i * 4), fill_word(WORD_ADDR_W'(i)), 4'hf);
      end
      credit_mode = 2;
      for (int i = 0; i < 300; i++) begin
         r_wr   = rand_bits(1);
         r_addr = rand_bits(ADDR_W);
         r_data = rand_bits(DATA_W);
         r_mask = rand_bits(MASK_W);
         send_req(r_wr[0], r_addr[ADDR_W-1:0], r_data, r_mask[MASK_W-1:0]);
      end
      credit_mode = 1;
      wait_drain();
      test_done("random traffic", err0);

      err0 = errors;
      idle(4);
      check("req_credit pulses", credit_pulses, reqs_sent);
      check("request credits", req_credits(), REQ_DEPTH);
      check("response credits left", rsp_out, 0);
      test_done("credit balance", err0);

      $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- dmem_subsystem.f
rtl/dmem_pkg.sv
rtl/sync_fifo.sv
rtl/mem_req_issue.sv
rtl/dmem_bram.sv
rtl/mem_rsp_egress.sv
rtl/dmem_subsystem.sv
dv/dmem_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = dmem_tb
FILELIST  = dmem_subsystem.f
OBJ_DIR   = obj_dir
PASS_MSG  = Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
